/* Makefile */
# Verilator build and run for the ADC acquisition front end.

SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: run

obj_dir/Vadc_acq_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module adc_acq_tb \
		-o Vadc_acq_tb

sim.log: obj_dir/Vadc_acq_tb adc_cases.txt
	./obj_dir/Vadc_acq_tb > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	! grep -q "Testbench failed" sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* adc_acq_checker.sv */
/*
 * Frame protocol assertions, bound into the acquisition top level.
 * Checks the idle clock level, tick timing and the sample strobe position.
 */
`timescale 1ns/10ps

module adc_acq_checker (
   input logic clk_50m,
   input logic rst_n,
   input logic i_cs,                                     // Chip select, low in a frame.
   input logic i_sclk,                                   // Serial clock.
   input logic i_start_tick,                             // Timer tick.
   input logic i_sample_valid                            // Raw sample strobe.
);

   // SCLK parks high whenever the ADC is deselected.
   assert property (@(posedge clk_50m) disable iff (!rst_n) i_cs |-> i_sclk)
      else $error("SCLK low while CS is high");

   // CS is high only in ST_IDLE, so a tick must meet CS high.
   assert property (@(posedge clk_50m) disable iff (!rst_n) i_start_tick |-> i_cs)
      else $error("start tick outside the idle state");

   // Sample strobe comes one cycle after CS rises.
   assert property (@(posedge clk_50m) disable iff (!rst_n) $rose(i_cs) |=> i_sample_valid)
      else $error("sample strobe not one cycle after CS rise");

endmodule

bind adc_acq_top adc_acq_checker adc_acq_checker_inst (
   .clk_50m        (clk_50m),
   .rst_n          (rst_n),
   .i_cs           (o_adc_cs),
   .i_sclk         (o_adc_sclk),
   .i_start_tick   (start_tick),
   .i_sample_valid (o_sample.valid)
);

/* adc_acq_tb.sv */
/*
 * Testbench for the ADC acquisition front end. Models the serial ADC,
 * reads samples and expected averages from adc_cases.txt and checks
 * samples, averages, frame shape, frame rate and disable/restart.
 */
`timescale 1ns/10ps

module adc_acq_tb
   import adc_pkg::*;
;

   localparam int unsigned SCLK_HALF     = 13;
   localparam int unsigned SAMPLE_PERIOD = 1000;
   localparam int unsigned AVG_LOG2      = 2;
   localparam int          NCASES        = 12;           // Lines in the case file.
   localparam int          DIS_CASE      = 6;            // Case preceded by disable/restart.
   localparam longint      FRAME_CYCLES  = 3 + 33 * SCLK_HALF; // Tick to sample strobe.
   localparam longint      WATCHDOG_NS   = (NCASES * 4 + 4) * SAMPLE_PERIOD * 20;

   logic        clk_50m = 1'b0;
   logic        rst_n;
   logic        i_enable;
   logic        i_adc_miso;
   logic        o_adc_cs;
   logic        o_adc_sclk;
   adc_out_t    o_sample;
   adc_out_t    o_avg;

   logic [15:0] case_mem [0:NCASES*6-1];                 // Id, four samples, average.
   adc_sample_t sent_q[$];                               // Samples waiting for a frame.
   logic [15:0] frame_word;                              // Zeros, sample, zeros.
   int          bit_n;                                   // Frame bit on MISO.
   int          errors = 0;
   int          avg_pulses = 0;
   longint      cycle = 0;
   longint      last_fall = -1;                          // Cycle of the previous CS fall.
   longint      tick_cycle = 0;
   int          falls = 0;                               // SCLK falls in this frame.
   logic        prev_cs = 1'b1;
   logic        prev_sclk = 1'b1;

   always #10 clk_50m = ~clk_50m;                        // 50 MHz.

   adc_acq_top #(
      .SCLK_HALF     (SCLK_HALF),
      .SAMPLE_PERIOD (SAMPLE_PERIOD),
      .AVG_LOG2      (AVG_LOG2)
   ) adc_acq_top_inst (
      .clk_50m    (clk_50m),
      .rst_n      (rst_n),
      .i_enable   (i_enable),
      .i_adc_miso (i_adc_miso),
      .o_adc_cs   (o_adc_cs),
      .o_adc_sclk (o_adc_sclk),
      .o_sample   (o_sample),
      .o_avg      (o_avg)
   );

   // ADC model: load the next queued sample as CS falls.
   always @(negedge o_adc_cs) begin
      if (rst_n) begin
         bit_n = 0;
         if (sent_q.size() == 0) begin
            errors++;
            $display("A frame started with no sample queued for the ADC model");
            frame_word = '0;
         end else begin
            frame_word = {3'b000, sent_q.pop_front(), 3'b000};
         end
      end
   end

   // Bit n goes out after SCLK fall n; non-data bits carry junk ones.
   always @(negedge o_adc_sclk) begin
      if (rst_n && !o_adc_cs) begin
         bit_n++;
         #2;
         if (bit_n >= DATA_FIRST && bit_n <= DATA_LAST)
            i_adc_miso = frame_word[16-bit_n];
         else
            i_adc_miso = 1'b1;                           // Must never be captured.
      end
   end

   // Frame shape, frame rate and latency monitor.
   always @(negedge clk_50m) begin
      cycle++;
      if (rst_n) begin
         if (prev_cs && !o_adc_cs) begin
            if (!i_enable) begin
               errors++;
               $display("A frame started while enable was low");
            end
            if (last_fall >= 0 && cycle - last_fall != SAMPLE_PERIOD) begin
               errors++;
               $display("CS falls %0d cycles apart", cycle - last_fall);
            end
            last_fall = cycle;
            falls     = 0;
         end
         if (!o_adc_cs && prev_sclk && !o_adc_sclk)
            falls++;
         if (!prev_cs && o_adc_cs && falls != FRAME_SCLKS) begin
            errors++;
            $display("Frame had %0d SCLK falls instead of 16", falls);
         end
         if (adc_acq_top_inst.start_tick)
            tick_cycle = cycle;
         if (o_sample.valid && cycle - tick_cycle != FRAME_CYCLES) begin
            errors++;
            $display("Tick to sample took %0d cycles", cycle - tick_cycle);
         end
         if (o_avg.valid)
            avg_pulses++;
         if (!i_enable)
            last_fall = -1;                              // Restart resets the rate check.
      end
      prev_cs   = o_adc_cs;
      prev_sclk = o_adc_sclk;
   end

   task automatic drive_point();
      @(posedge clk_50m);
      #2;
   endtask

   task automatic check_idle_cycles(input int n);
      for (int k = 0; k < n; k++) begin
         @(negedge clk_50m);
         if (o_adc_cs !== 1'b1 || o_adc_sclk !== 1'b1 || o_sample.valid || o_avg.valid) begin
            errors++;
            $display("Outputs not idle before enable");
         end
      end
   endtask

   task automatic wait_strobe(input bit is_avg, output adc_out_t got);
      int n;
      n = 0;
      do begin
         @(negedge clk_50m);
         n++;
      end while (!(is_avg ? o_avg.valid : o_sample.valid) && n < 2 * SAMPLE_PERIOD);
      got = is_avg ? o_avg : o_sample;
      if (!got.valid) begin
         errors++;
         $display("No %s strobe within %0d cycles", is_avg ? "average" : "sample", n);
      end
   endtask

   task automatic check_sample(input adc_out_t got, input adc_sample_t exp);
      if (got.sample !== exp) begin
         errors++;
         $display("[ERROR] o_sample.sample: got %h, expected %h", got.sample, exp);
      end
   endtask

   task automatic check_avg(input adc_out_t got, input adc_sample_t exp);
      if (got.sample !== exp) begin
         errors++;
         $display("[ERROR] o_avg.sample: got %h, expected %h", got.sample, exp);
      end
   endtask

   // Two samples of a group, then a pause; the partial group must vanish.
   task automatic disable_and_restart();
      adc_out_t got;
      sent_q.push_back(10'h155);
      wait_strobe(1'b0, got);
      check_sample(got, 10'h155);
      sent_q.push_back(10'h2AA);
      wait_strobe(1'b0, got);
      check_sample(got, 10'h2AA);
      drive_point();
      i_enable = 1'b0;
      repeat (600) drive_point();                        // Outlasts the next tick of a free timer.
      i_enable = 1'b1;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      adc_out_t    got;
      adc_sample_t vals [4];
      int          errs_before;
      int          bad_cases;
      rst_n      = 1'b1;
      i_enable   = 1'b0;
      i_adc_miso = 1'b1;
      bad_cases  = 0;
      $readmemh("adc_cases.txt", case_mem);
      #1 rst_n = 1'b0;                                   // Clean reset edge.
      check_idle_cycles(10);
      drive_point();
      rst_n = 1'b1;
      check_idle_cycles(20);
      drive_point();
      i_enable = 1'b1;
      for (int c = 0; c < NCASES; c++) begin
         errs_before = errors;
         if (c == DIS_CASE)
            disable_and_restart();
         for (int j = 0; j < 4; j++) begin
            vals[j] = case_mem[c*6+1+j][ADC_BITS-1:0];
            sent_q.push_back(vals[j]);
            wait_strobe(1'b0, got);
            check_sample(got, vals[j]);
         end
         wait_strobe(1'b1, got);
         check_avg(got, case_mem[c*6+5][ADC_BITS-1:0]);
         if (errors != errs_before)
            bad_cases++;
         $display("case %h: %h %h %h %h avg %h %s", case_mem[c*6][7:0], vals[0], vals[1],
                  vals[2], vals[3], got.sample, (errors == errs_before) ? "ok" : "FAILED");
      end
      repeat (4) @(negedge clk_50m);
      if (avg_pulses != NCASES) begin
         errors++;
         $display("Saw %0d average strobes instead of %0d", avg_pulses, NCASES);
      end
      $display("cases %0d, failed %0d, errors %0d", NCASES, bad_cases, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* adc_acq_top.sv */
/*
 * Acquisition front end top level. Sets the timing parameters and wires
 * the sample timer, frame FSM, SCLK generator, receiver and averager.
 */
`timescale 1ns/10ps

module adc_acq_top
   import adc_pkg::*;
#(
   parameter int unsigned SCLK_HALF     = 13,            // Clocks per SCLK half period.
   parameter int unsigned SAMPLE_PERIOD = 1000,          // Clocks between frames.
   parameter int unsigned AVG_LOG2      = 2              // Four samples per average.
) (
   input  logic     clk_50m,
   input  logic     rst_n,
   input  logic     i_enable,                            // Acquisition on.
   input  logic     i_adc_miso,
   output logic     o_adc_cs,
   output logic     o_adc_sclk,
   output adc_out_t o_sample,                            // Every captured sample.
   output adc_out_t o_avg                                // Group averages.
);

   logic         start_tick;                             // Timer to FSM.
   logic         sclk_run;                               // FSM to SCLK generator.
   logic         data_win;                               // FSM to receiver.
   logic         frame_end;                              // FSM to receiver.
   sclk_status_t sclk_status;                            // SCLK generator to FSM and receiver.

   adc_sample_timer #(
      .SAMPLE_PERIOD (SAMPLE_PERIOD)
   ) adc_sample_timer_inst (
      .clk_50m      (clk_50m),
      .rst_n        (rst_n),
      .i_enable     (i_enable),
      .o_start_tick (start_tick)
   );

   adc_spi_fsm adc_spi_fsm_inst (
      .clk_50m      (clk_50m),
      .rst_n        (rst_n),
      .i_start_tick (start_tick),
      .i_sclk       (sclk_status),
      .o_adc_cs     (o_adc_cs),
      .o_sclk_run   (sclk_run),
      .o_data_win   (data_win),
      .o_frame_end  (frame_end)
   );

   adc_sclk_gen #(
      .SCLK_HALF (SCLK_HALF)
   ) adc_sclk_gen_inst (
      .clk_50m    (clk_50m),
      .rst_n      (rst_n),
      .i_sclk_run (sclk_run),
      .o_adc_sclk (o_adc_sclk),
      .o_sclk     (sclk_status)
   );

   adc_shift_rx adc_shift_rx_inst (
      .clk_50m     (clk_50m),
      .rst_n       (rst_n),
      .i_adc_miso  (i_adc_miso),
      .i_sclk      (sclk_status),
      .i_data_win  (data_win),
      .i_frame_end (frame_end),
      .o_sample    (o_sample)
   );

   adc_avg_accum #(
      .AVG_LOG2 (AVG_LOG2)
   ) adc_avg_accum_inst (
      .clk_50m  (clk_50m),
      .rst_n    (rst_n),
      .i_enable (i_enable),
      .i_sample (o_sample),                              // Raw samples feed the averager too.
      .o_avg    (o_avg)
   );

endmodule

/* adc_avg_accum.sv */
/*
 * Group averager. Sums 2^AVG_LOG2 valid samples and delivers the floor
 * average with a one-cycle strobe after the last sample of the group.
 * Dropping enable discards a partial group.
 */
`timescale 1ns/10ps

module adc_avg_accum
   import adc_pkg::*;
#(
   parameter int unsigned AVG_LOG2 = 2                   // Log2 of samples per average.
) (
   input  logic     clk_50m,
   input  logic     rst_n,
   input  logic     i_enable,                            // Low clears the running group.
   input  adc_out_t i_sample,                            // Raw samples.
   output adc_out_t o_avg                                // Floor average and strobe.
);

   localparam int unsigned SUM_W = ADC_BITS + AVG_LOG2;  // Full group sum fits.
   localparam int unsigned CNT_W = AVG_LOG2 + 1;
   localparam int unsigned GROUP = 1 << AVG_LOG2;

   logic [SUM_W-1:0] sum_q;                              // Running sum of the group.
   logic [SUM_W-1:0] sum_next;                           // Sum including this sample.
   logic [CNT_W-1:0] count_q;                            // Samples already summed.
   logic             group_last;                         // This sample closes the group.
   adc_sample_t      avg_q;
   logic             valid_q;

   assign sum_next   = sum_q + SUM_W'(i_sample.sample);
   assign group_last = (count_q == CNT_W'(GROUP - 1));

   always_ff @(posedge clk_50m or negedge rst_n) begin
      if (!rst_n) begin
         sum_q   <= '0;
         count_q <= '0;
         valid_q <= 1'b0;
      end else if (!i_enable) begin
         sum_q   <= '0;                                  // Partial group thrown away.
         count_q <= '0;
         valid_q <= 1'b0;
      end else if (i_sample.valid && group_last) begin
         sum_q   <= '0;
         count_q <= '0;
         valid_q <= 1'b1;
      end else if (i_sample.valid) begin
         sum_q   <= sum_next;
         count_q <= count_q + 1'b1;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_50m) begin
      if (i_enable && i_sample.valid && group_last)
         avg_q <= ADC_BITS'(sum_next >> AVG_LOG2);       // Shift gives the floor.
   end

   assign o_avg = '{valid: valid_q, sample: avg_q};

endmodule

/* adc_cases.txt */
// Columns: case id, sample 0, sample 1, sample 2, sample 3, expected floor average.
// All values hex; samples are 10-bit words fed to the ADC model in frame order.
01 000 000 000 000 000
02 3FF 3FF 3FF 3FF 3FF
03 155 2AA 155 2AA 1FF
04 001 002 003 004 002
05 3FF 000 3FF 000 1FF
06 200 100 080 040 0F0
07 123 045 378 2BC 1E7
08 3FE 3FD 3FC 3FB 3FC
09 001 000 000 000 000
0A 0AA 0AA 0AA 0AB 0AA
0B 2D4 06B 1F0 30F 20F
0C 3FF 3FF 3FF 3FC 3FE

/* adc_pkg.sv */
/*
 * Shared definitions for the serial ADC acquisition front end.
 * Frame constants, the sample word, the SCLK status bundle, the output
 * bundle and the frame state enum. Modules pull it in by wildcard import.
 */
package adc_pkg;

   localparam int unsigned ADC_BITS    = 10;              // Sample width.
   localparam int unsigned FRAME_SCLKS = 16;              // SCLK cycles per frame.
   localparam int unsigned DATA_FIRST  = 4;               // First rising edge with data.
   localparam int unsigned DATA_LAST   = 13;              // Last rising edge with data.
   localparam int unsigned FRAME_DONE  = FRAME_SCLKS + 1; // Index once the final high half ends.
   localparam int unsigned IDX_W       = 5;               // Width of the edge index.

   typedef logic [ADC_BITS-1:0] adc_sample_t;             // Unsigned ADC sample.
   typedef logic [IDX_W-1:0]    edge_idx_t;               // SCLK cycle number within a frame.

   // SCLK generator status, seen by the FSM and the receiver.
   typedef struct packed {
      logic      rise;                                    // SCLK went high this cycle.
      logic      fall;                                    // SCLK went low this cycle.
      edge_idx_t edge_idx;                                // Falling edges seen so far.
   } sclk_status_t;

   // Raw and averaged sample outputs.
   typedef struct packed {
      logic        valid;                                 // One-cycle strobe.
      adc_sample_t sample;                                // Holds until the next strobe.
   } adc_out_t;

   // Frame sequencing states.
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,                                    // CS high, waiting for a tick.
      ST_LEAD  = 3'd1,                                    // Leading zero bits.
      ST_DATA  = 3'd2,                                    // Ten data bits.
      ST_TRAIL = 3'd3,                                    // Trailing zero bits.
      ST_END   = 3'd4                                     // Final high half, then CS up.
   } spi_state_e;

endpackage

/* adc_sample_timer.sv */
/*
 * Sample-rate timer. Emits a one-cycle start tick every SAMPLE_PERIOD
 * clocks while enabled; the count restarts whenever enable is low, so the
 * first tick comes one full period after enable rises.
 */
`timescale 1ns/10ps

module adc_sample_timer #(
   parameter int unsigned SAMPLE_PERIOD = 1000           // Clocks between frame starts.
) (
   input  logic clk_50m,
   input  logic rst_n,
   input  logic i_enable,                                // Acquisition enable level.
   output logic o_start_tick                             // One-cycle frame start pulse.
);

   localparam int unsigned CNT_W = $clog2(SAMPLE_PERIOD);

   logic [CNT_W-1:0] period_cnt;                         // Clocks into the current period.

   always_ff @(posedge clk_50m or negedge rst_n) begin
      if (!rst_n) begin
         period_cnt   <= '0;
         o_start_tick <= 1'b0;
      end else if (!i_enable) begin
         period_cnt   <= '0;                             // Hold off until re-enabled.
         o_start_tick <= 1'b0;
      end else if (period_cnt == CNT_W'(SAMPLE_PERIOD - 1)) begin
         period_cnt   <= '0;                             // Wrap and fire.
         o_start_tick <= 1'b1;
      end else begin
         period_cnt   <= period_cnt + 1'b1;
         o_start_tick <= 1'b0;
      end
   end

endmodule

/* adc_sclk_gen.sv */
/*
 * SCLK generator. Divides clk_50m by 2*SCLK_HALF while run is high and
 * reports rise/fall strobes plus the falling edge count. After the 16th
 * rising edge it times one more high half and then flags FRAME_DONE.
 */
`timescale 1ns/10ps

module adc_sclk_gen
   import adc_pkg::*;
#(
   parameter int unsigned SCLK_HALF = 13                 // Clocks per SCLK half period.
) (
   input  logic         clk_50m,
   input  logic         rst_n,
   input  logic         i_sclk_run,                      // Frame in progress.
   output logic         o_adc_sclk,                      // Serial clock to the ADC.
   output sclk_status_t o_sclk                           // Edge strobes and edge index.
);

   localparam int unsigned CNT_W = $clog2(SCLK_HALF);

   logic [CNT_W-1:0] half_cnt;                           // Clocks into the current half.
   logic             half_end;                           // Last clock of a half period.
   logic             frame_done;                         // Final high half already timed.

   assign half_end   = (half_cnt == CNT_W'(SCLK_HALF - 1));
   assign frame_done = (o_sclk.edge_idx == edge_idx_t'(FRAME_DONE));

   always_ff @(posedge clk_50m or negedge rst_n) begin
      if (!rst_n) begin
         half_cnt   <= '0;
         o_adc_sclk <= 1'b1;                             // Idle level is high.
         o_sclk     <= '0;
      end else if (!i_sclk_run) begin
         half_cnt   <= '0;                               // Park high, counters cleared.
         o_adc_sclk <= 1'b1;
         o_sclk     <= '0;
      end else begin
         o_sclk.rise <= 1'b0;
         o_sclk.fall <= 1'b0;
         if (!frame_done) begin
            if (half_end) begin
               half_cnt <= '0;
               if (o_adc_sclk && o_sclk.edge_idx == edge_idx_t'(FRAME_SCLKS)) begin
                  o_sclk.edge_idx <= edge_idx_t'(FRAME_DONE); // No 17th fall, just mark the end.
               end else if (o_adc_sclk) begin
                  o_adc_sclk      <= 1'b0;
                  o_sclk.fall     <= 1'b1;
                  o_sclk.edge_idx <= o_sclk.edge_idx + 1'b1;
               end else begin
                  o_adc_sclk  <= 1'b1;
                  o_sclk.rise <= 1'b1;                   // ADC data is sampled here.
               end
            end else begin
               half_cnt <= half_cnt + 1'b1;
            end
         end
      end
   end

endmodule

/* adc_shift_rx.sv */
/*
 * Serial receiver. Synchronizes MISO, shifts it in MSB first on SCLK
 * rising edges inside the data window and presents the sample with a
 * one-cycle valid strobe the cycle after frame_end.
 */
`timescale 1ns/10ps

module adc_shift_rx
   import adc_pkg::*;
(
   input  logic         clk_50m,
   input  logic         rst_n,
   input  logic         i_adc_miso,                      // Serial data from the ADC.
   input  sclk_status_t i_sclk,                          // Rise strobe marks the sample point.
   input  logic         i_data_win,                      // Data bits only.
   input  logic         i_frame_end,                     // Frame finished, word complete.
   output adc_out_t     o_sample                         // Captured sample and strobe.
);

   logic [1:0]  miso_sync;                               // Two-flop synchronizer.
   adc_sample_t shift_q;                                 // Bits arriving MSB first.
   adc_sample_t sample_q;                                // Last complete sample.
   logic        valid_q;

   always_ff @(posedge clk_50m) begin
      miso_sync <= {miso_sync[0], i_adc_miso};
      if (i_sclk.rise && i_data_win)
         shift_q <= {shift_q[ADC_BITS-2:0], miso_sync[1]}; // Ten rises fill the word.
      if (i_frame_end)
         sample_q <= shift_q;                            // Holds until the next frame.
   end

   always_ff @(posedge clk_50m or negedge rst_n) begin
      if (!rst_n)
         valid_q <= 1'b0;
      else
         valid_q <= i_frame_end;                         // One cycle after frame_end.
   end

   assign o_sample = '{valid: valid_q, sample: sample_q};

endmodule

/* adc_spi_fsm.sv */
/*
 * Frame sequencer. Drops CS on a start tick, runs the SCLK generator,
 * opens the data window around rising edges DATA_FIRST..DATA_LAST and
 * raises CS with a frame_end pulse once the final high half is over.
 */
`timescale 1ns/10ps

module adc_spi_fsm
   import adc_pkg::*;
(
   input  logic         clk_50m,
   input  logic         rst_n,
   input  logic         i_start_tick,                    // Start of a conversion frame.
   input  sclk_status_t i_sclk,                          // Status from the SCLK generator.
   output logic         o_adc_cs,                        // Active-low chip select.
   output logic         o_sclk_run,                      // Lets the SCLK generator run.
   output logic         o_data_win,                      // Data bits are on MISO.
   output logic         o_frame_end                      // One-cycle pulse as CS rises.
);

   spi_state_e state;
   spi_state_e next_state;
   logic       lead_done;                                // Fall before the first data rise.
   logic       data_done;                                // Last data bit captured.
   logic       trail_done;                               // 16th rising edge.
   logic       end_done;                                 // Final high half timed out.

   assign lead_done  = i_sclk.fall && (i_sclk.edge_idx == edge_idx_t'(DATA_FIRST));
   assign data_done  = i_sclk.rise && (i_sclk.edge_idx == edge_idx_t'(DATA_LAST));
   assign trail_done = i_sclk.rise && (i_sclk.edge_idx == edge_idx_t'(FRAME_SCLKS));
   assign end_done   = (i_sclk.edge_idx == edge_idx_t'(FRAME_DONE));

   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE: begin
            if (i_start_tick)
               next_state = ST_LEAD;                     // Ticks elsewhere are ignored.
         end
         ST_LEAD: begin
            if (lead_done)
               next_state = ST_DATA;
         end
         ST_DATA: begin
            if (data_done)
               next_state = ST_TRAIL;
         end
         ST_TRAIL: begin
            if (trail_done)
               next_state = ST_END;
         end
         ST_END: begin
            if (end_done)
               next_state = ST_IDLE;
         end
         default: next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_50m or negedge rst_n) begin
      if (!rst_n)
         state <= ST_IDLE;
      else
         state <= next_state;
   end

   // CS and frame_end are registered so they change together with the state.
   always_ff @(posedge clk_50m or negedge rst_n) begin
      if (!rst_n) begin
         o_adc_cs    <= 1'b1;
         o_frame_end <= 1'b0;
      end else begin
         o_frame_end <= 1'b0;
         if (state == ST_IDLE && i_start_tick) begin
            o_adc_cs <= 1'b0;                            // Frame begins.
         end else if (state == ST_END && end_done) begin
            o_adc_cs    <= 1'b1;                         // Release the ADC.
            o_frame_end <= 1'b1;
         end
      end
   end

   assign o_sclk_run = (state != ST_IDLE);               // Drops as the FSM returns to idle.
   assign o_data_win = (state == ST_DATA);

endmodule

/* sim.f */
adc_pkg.sv
adc_sample_timer.sv
adc_sclk_gen.sv
adc_spi_fsm.sv
adc_shift_rx.sv
adc_avg_accum.sv
adc_acq_top.sv
adc_acq_checker.sv
adc_acq_tb.sv
